/* Makefile */
SIM = obj_dir/Vcsr_amo_core_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module csr_amo_core_tb -f csr_amo_core.f

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

/* common/amo_pkg.sv */
`include "core_consts.svh"

package amo_pkg;

   typedef enum logic [3:0] {
      AMO_SWAP = 4'd0,
      AMO_ADD  = 4'd1,
      AMO_AND  = 4'd2,
      AMO_OR   = 4'd3,
      AMO_XOR  = 4'd4,
      AMO_MAX  = 4'd5,
      AMO_MIN  = 4'd6,
      AMO_MAXU = 4'd7,
      AMO_MINU = 4'd8
   } amo_op_t;

   // which unit a command goes to
   typedef enum logic {
      CMD_CSR = 1'b0,
      CMD_AMO = 1'b1
   } cmd_kind_t;

   // byte lanes of one bus word
   typedef logic [`XLEN/8-1:0] mem_strb_t;

endpackage

/* common/core_consts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

`define XLEN 32

// machine csr addresses
`define CSR_MSTATUS  12'h300
`define CSR_MISA     12'h301
`define CSR_MIE      12'h304
`define CSR_MTVEC    12'h305
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC     12'h341
`define CSR_MCAUSE   12'h342
`define CSR_MTVAL    12'h343
`define CSR_MCYCLE   12'hB00
`define CSR_MCYCLEH  12'hB80
`define CSR_MHARTID  12'hF14

// writable fields: mie, mpie, mpp / msie, mtie, meie
`define MSTATUS_WMASK 32'h0000_1888
`define MIE_WMASK     32'h0000_0888

// rv32 with a, i and m
`define MISA_VALUE    32'h4000_1101
`define MHARTID_VALUE 32'h0000_0000
// mpp parked at machine level
`define MSTATUS_RESET 32'h0000_1800
`define MTVEC_RESET   32'h0000_0000

`endif

/* common/core_ifs.sv */
`include "core_consts.svh"

////////////////////////////////////////////////////////////////////////////
// controller to csr file
////////////////////////////////////////////////////////////////////////////

interface csr_if;
   import csr_pkg::*;

   csr_addr_t        addr;
   csr_op_t          op;
   logic [`XLEN-1:0] src;
   // rs1 index, doubles as the zero-extended immediate
   logic [4:0]       zimm;
   logic             wr_req;
   logic             trap_req;
   irq_cause_t       trap_cause;
   logic [`XLEN-1:0] trap_pc;
   logic [`XLEN-1:0] rdata;
   logic             legal;

   modport ctrl (output addr, op, src, zimm, wr_req, trap_req, trap_cause, trap_pc,
                 input  rdata, legal);
   modport csr  (input  addr, op, src, zimm, wr_req, trap_req, trap_cause, trap_pc,
                 output rdata, legal);
endinterface

////////////////////////////////////////////////////////////////////////////
// controller to memory port
////////////////////////////////////////////////////////////////////////////

interface mem_if;
   logic             start;
   logic             write;
   logic [`XLEN-1:0] addr;
   logic [`XLEN-1:0] wdata;
   logic             done;
   logic [`XLEN-1:0] rdata;

   modport ctrl (output start, write, addr, wdata, input  done, rdata);
   modport port (input  start, write, addr, wdata, output done, rdata);
endinterface

/* common/csr_pkg.sv */
package csr_pkg;

   // funct3 encoding, bit 2 marks the immediate forms
   typedef enum logic [2:0] {
      CSRRW  = 3'b001,
      CSRRS  = 3'b010,
      CSRRC  = 3'b011,
      CSRRWI = 3'b101,
      CSRRSI = 3'b110,
      CSRRCI = 3'b111
   } csr_op_t;

   typedef logic [11:0] csr_addr_t;

   // machine-level interrupt codes for mcause
   typedef enum logic [3:0] {
      IRQ_M_SOFT  = 4'd3,
      IRQ_M_TIMER = 4'd7,
      IRQ_M_EXT   = 4'd11
   } irq_cause_t;

endpackage

/* csr/csr_file.sv */
`include "core_consts.svh"

module csr_file (
   input  logic clk,
   input  logic rstn,
   csr_if.csr   bus
);
   import csr_pkg::*;

   logic [`XLEN-1:0] mstatus;
   logic [`XLEN-1:0] mie;
   logic [`XLEN-1:0] mtvec;
   logic [`XLEN-1:0] mscratch;
   logic [`XLEN-1:0] mepc;
   logic [`XLEN-1:0] mcause;
   logic [`XLEN-1:0] mtval;
   logic [63:0]      mcycle;
   logic [`XLEN-1:0] old_val;
   logic [`XLEN-1:0] src_val;
   logic [`XLEN-1:0] new_val;
   logic             known;
   logic             wr_intent;
   logic             wr_en;

   ////////////////////////////////////////////////////////////////////////////
   // read decode
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      known = 1'b1;
      case (bus.addr)
         `CSR_MSTATUS:  old_val = mstatus;
         `CSR_MISA:     old_val = `MISA_VALUE;
         `CSR_MIE:      old_val = mie;
         `CSR_MTVEC:    old_val = mtvec;
         `CSR_MSCRATCH: old_val = mscratch;
         `CSR_MEPC:     old_val = mepc;
         `CSR_MCAUSE:   old_val = mcause;
         `CSR_MTVAL:    old_val = mtval;
         `CSR_MCYCLE:   old_val = mcycle[31:0];
         `CSR_MCYCLEH:  old_val = mcycle[63:32];
         `CSR_MHARTID:  old_val = `MHARTID_VALUE;
         default: begin
            known   = 1'b0;
            old_val = '0;
         end
      endcase
   end

   assign bus.rdata = old_val;

   // set and clear with a zero source index only read
   assign wr_intent = (bus.op == CSRRW) || (bus.op == CSRRWI) || (bus.zimm != 5'd0);
   // top address bits 11 mark the read-only space
   assign bus.legal = known && !(wr_intent && (bus.addr[11:10] == 2'b11));
   assign wr_en     = bus.wr_req && bus.legal && wr_intent;

   ////////////////////////////////////////////////////////////////////////////
   // read-modify-write value
   ////////////////////////////////////////////////////////////////////////////

   assign src_val = bus.op[2] ? {{(`XLEN-5){1'b0}}, bus.zimm} : bus.src;

   always_comb begin
      case (bus.op)
         CSRRW, CSRRWI: new_val = src_val;
         CSRRS, CSRRSI: new_val = old_val | src_val;
         default:       new_val = old_val & ~src_val;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rstn) begin
         mstatus  <= `MSTATUS_RESET;
         mie      <= '0;
         mtvec    <= `MTVEC_RESET;
         mscratch <= '0;
         mepc     <= '0;
         mcause   <= '0;
         mtval    <= '0;
         mcycle   <= '0;
      end else begin
         mcycle <= mcycle + 64'd1;
         if (wr_en) begin
            case (bus.addr)
               `CSR_MSTATUS:
                  mstatus <= (mstatus & ~`MSTATUS_WMASK) | (new_val & `MSTATUS_WMASK);
               `CSR_MIE:
                  mie <= (mie & ~`MIE_WMASK) | (new_val & `MIE_WMASK);
               `CSR_MTVEC: begin
                  // modes 2 and 3 are reserved
                  if (new_val[1:0] < 2'd2) begin
                     mtvec <= new_val;
                  end
               end
               `CSR_MSCRATCH: mscratch      <= new_val;
               `CSR_MEPC:     mepc          <= {new_val[`XLEN-1:2], 2'b00};
               `CSR_MCAUSE:   mcause        <= new_val;
               `CSR_MTVAL:    mtval         <= new_val;
               `CSR_MCYCLE:   mcycle[31:0]  <= new_val;
               `CSR_MCYCLEH:  mcycle[63:32] <= new_val;
               default: ;
            endcase
         end
         // interrupt capture wins over a software write
         if (bus.trap_req) begin
            mcause <= {1'b1, {(`XLEN-5){1'b0}}, bus.trap_cause};
            mepc   <= {bus.trap_pc[`XLEN-1:2], 2'b00};
         end
      end
   end

   a_illegal_no_write: assert property (@(posedge clk) disable iff (rstn)
      (bus.wr_req && !bus.legal && !bus.trap_req) |=>
         ($stable(mstatus) && $stable(mie) && $stable(mtvec) && $stable(mscratch)
          && $stable(mepc) && $stable(mcause) && $stable(mtval)));

endmodule

/* csr_amo_core.f */
+incdir+common
common/csr_pkg.sv
common/amo_pkg.sv
common/core_ifs.sv
csr/csr_file.sv
verilog/amo_alu.sv
verilog/mem_port.sv
verilog/sys_ctrl.sv
verilog/csr_amo_core.sv
tb/bus_responder.sv
tb/csr_amo_core_tb.sv

/* tb/bus_responder.sv */
`include "core_consts.svh"

module bus_responder (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 mem_request_enable,
   input  logic                 mreq_mode,
   input  logic [`XLEN-1:0]     mreq_addr,
   input  logic [`XLEN-1:0]     mreq_wdata,
   input  logic [`XLEN/8-1:0]   mreq_wstrb,
   output logic                 mem_response_enable,
   output logic [`XLEN-1:0]     mresp_data
);
   timeunit 1ns;
   timeprecision 100ps;

   logic [`XLEN-1:0] mem [0:255];
   int               seed;
   int               delay;
   logic [7:0]       idx;

   // word addressed, byte address bits 1:0 ignored
   task automatic preload(input logic [`XLEN-1:0] addr, input logic [`XLEN-1:0] data);
      mem[addr[9:2]] = data;
   endtask

   function automatic logic [`XLEN-1:0] peek(input logic [`XLEN-1:0] addr);
      return mem[addr[9:2]];
   endfunction

   initial begin
      seed                = 32'h3b97a570;
      delay               = 0;
      idx                 = '0;
      mem_response_enable = 1'b0;
      mresp_data          = '0;
      for (int i = 0; i < 256; i++) begin
         mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, i[7:0] + 8'h33};
      end
      forever begin
         @(posedge clk);
         #1;
         if (!rstn && mem_request_enable) begin
            idx   = mreq_addr[9:2];
            // 1 to 4 cycles until the response edge
            delay = 1 + ($random(seed) & 3);
            repeat (delay - 1) begin
               @(posedge clk);
               #1;
            end
            if (mreq_mode) begin
               for (int b = 0; b < `XLEN/8; b++) begin
                  if (mreq_wstrb[b]) begin
                     mem[idx][8*b +: 8] = mreq_wdata[8*b +: 8];
                  end
               end
            end else begin
               mresp_data = mem[idx];
            end
            mem_response_enable = 1'b1;
            @(posedge clk);
            #1;
            mem_response_enable = 1'b0;
         end
      end
   end

endmodule

/* tb/csr_amo_core_tb.sv */
`include "core_consts.svh"

module csr_amo_core_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import csr_pkg::*;
   import amo_pkg::*;

   localparam int WAIT_LIMIT = 64;

   logic               clk;
   logic               rstn;
   logic               cmd_valid;
   cmd_kind_t          cmd_kind;
   csr_op_t            cmd_csr_op;
   amo_op_t            cmd_amo_op;
   csr_addr_t          cmd_csr_addr;
   logic [4:0]         cmd_rs1_idx;
   logic [`XLEN-1:0]   cmd_rs1;
   logic [`XLEN-1:0]   cmd_rs2;
   logic [`XLEN-1:0]   cmd_pc;
   logic               busy;
   logic               done;
   logic               illegal;
   logic [`XLEN-1:0]   result;
   logic               mem_request_enable;
   logic               mreq_mode;
   logic [`XLEN-1:0]   mreq_addr;
   logic [`XLEN-1:0]   mreq_wdata;
   mem_strb_t          mreq_wstrb;
   logic               mem_response_enable;
   logic [`XLEN-1:0]   mresp_data;
   logic               software_intr;
   logic               timer_intr;
   logic               ext_intr;

   int                 errors;
   int                 tests_run;
   int                 tests_failed;
   logic               timed_out;
   // outcome of the last command
   logic [`XLEN-1:0]   last_result;
   logic               last_illegal;
   int                 last_cycles;

   csr_amo_core csr_amo_core_inst (.*);

   bus_responder bus_mem (.*);

   always #2 clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////////////////////

   task automatic expect_eq(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] want,
                            input string what);
      assert (got === want) else begin
         $display("CHECK FAILED at %0d ns: %s, got %h, expected %h", $time, what, got, want);
         errors++;
      end
   endtask

   task automatic expect_bit(input logic got, input logic want, input string what);
      assert (got === want) else begin
         $display("CHECK FAILED at %0d ns: %s, got %b, expected %b", $time, what, got, want);
         errors++;
      end
   endtask

   // starts 1 ns after an edge, returns 1 ns after the edge that shows done
   task automatic issue_cmd(input cmd_kind_t kind, input csr_op_t csr_op,
                            input amo_op_t amo_op, input csr_addr_t addr,
                            input logic [4:0] idx, input logic [`XLEN-1:0] rs1,
                            input logic [`XLEN-1:0] rs2, input logic [`XLEN-1:0] pc);
      int n;
      n = 0;
      if (timed_out) return;
      while (busy && n < WAIT_LIMIT) begin
         @(posedge clk);
         #1;
         n++;
      end
      if (busy) begin
         $display("timeout: the core stayed busy and never took a new command");
         errors++;
         timed_out = 1'b1;
         return;
      end
      cmd_kind     = kind;
      cmd_csr_op   = csr_op;
      cmd_amo_op   = amo_op;
      cmd_csr_addr = addr;
      cmd_rs1_idx  = idx;
      cmd_rs1      = rs1;
      cmd_rs2      = rs2;
      cmd_pc       = pc;
      cmd_valid    = 1'b1;
      @(posedge clk);
      #1;
      cmd_valid = 1'b0;
      // count edges after the one that sampled cmd_valid
      n = 0;
      while (!done && n < WAIT_LIMIT) begin
         @(posedge clk);
         #1;
         n++;
      end
      last_cycles = n;
      if (!done) begin
         $display("timeout: done never came back for the command at %0d ns", $time);
         errors++;
         timed_out = 1'b1;
      end else begin
         last_result  = result;
         last_illegal = illegal;
      end
   endtask

   task automatic csr_access(input csr_op_t op, input csr_addr_t addr, input logic [4:0] idx,
                             input logic [`XLEN-1:0] src,
                             input logic [`XLEN-1:0] pc = 32'h0000_0100);
      issue_cmd(CMD_CSR, op, AMO_SWAP, addr, idx, src, '0, pc);
   endtask

   // csrrs with x0 only reads
   task automatic read_csr(input csr_addr_t addr, output logic [`XLEN-1:0] value);
      csr_access(CSRRS, addr, 5'd0, '0);
      value = last_result;
   endtask

   task automatic finish_test(input string name, input int start_errors);
      tests_run++;
      if (errors > start_errors) begin
         tests_failed++;
         $display("%s: FAIL, %0d check(s) wrong", name, errors - start_errors);
      end else begin
         $display("%s: ok", name);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // tests
   ////////////////////////////////////////////////////////////////////////////

   task automatic reset_state();
      int start_errors;
      start_errors = errors;
      for (int i = 0; i < 16; i++) begin
         @(posedge clk);
         #1;
         expect_bit(done, 1'b0, "done during reset");
         expect_bit(busy, 1'b0, "busy during reset");
         expect_bit(mem_request_enable, 1'b0, "bus request during reset");
      end
      rstn = 1'b0;
      repeat (3) begin
         @(posedge clk);
         #1;
         expect_bit(done, 1'b0, "done after reset");
         expect_bit(busy, 1'b0, "busy after reset");
         expect_bit(mem_request_enable, 1'b0, "bus request after reset");
      end
      finish_test("reset state", start_errors);
   endtask

   task automatic mscratch_rmw();
      int               start_errors;
      logic [`XLEN-1:0] value;
      start_errors = errors;
      csr_access(CSRRW, `CSR_MSCRATCH, 5'd3, 32'h1234_5678);
      expect_eq(last_result, 32'h0, "csrrw returns the reset value");
      expect_eq(last_cycles, 2, "csrrw done latency");
      csr_access(CSRRS, `CSR_MSCRATCH, 5'd4, 32'h0000_000F);
      expect_eq(last_result, 32'h1234_5678, "csrrs returns the written value");
      expect_eq(last_cycles, 2, "csrrs done latency");
      csr_access(CSRRC, `CSR_MSCRATCH, 5'd5, 32'h0000_00F0);
      expect_eq(last_result, 32'h1234_567F, "csrrc sees the set bits");
      expect_eq(last_cycles, 2, "csrrc done latency");
      // x0 as source index, so the nonzero value must not land
      csr_access(CSRRS, `CSR_MSCRATCH, 5'd0, 32'hFFFF_FFFF);
      expect_eq(last_result, 32'h1234_560F, "csrrc cleared the upper nibble");
      expect_eq(last_cycles, 2, "csrrs x0 done latency");
      read_csr(`CSR_MSCRATCH, value);
      expect_eq(value, 32'h1234_560F, "csrrs with x0 wrote mscratch");
      finish_test("mscratch read-modify-write", start_errors);
   endtask

   task automatic write_masks();
      int               start_errors;
      logic [`XLEN-1:0] value;
      start_errors = errors;
      csr_access(CSRRW, `CSR_MSTATUS, 5'd1, 32'hFFFF_FFFF);
      read_csr(`CSR_MSTATUS, value);
      expect_eq(value, `MSTATUS_WMASK, "mstatus after all ones");
      csr_access(CSRRW, `CSR_MIE, 5'd1, 32'hFFFF_FFFF);
      read_csr(`CSR_MIE, value);
      expect_eq(value, `MIE_WMASK, "mie after all ones");
      csr_access(CSRRW, `CSR_MTVEC, 5'd1, 32'h0000_2001);
      read_csr(`CSR_MTVEC, value);
      expect_eq(value, 32'h0000_2001, "mtvec vectored mode");
      // reserved mode is dropped
      csr_access(CSRRW, `CSR_MTVEC, 5'd1, 32'h0000_3002);
      read_csr(`CSR_MTVEC, value);
      expect_eq(value, 32'h0000_2001, "mtvec after mode 2 write");
      csr_access(CSRRW, `CSR_MEPC, 5'd1, 32'h0000_4447);
      read_csr(`CSR_MEPC, value);
      expect_eq(value, 32'h0000_4444, "mepc low bits");
      read_csr(`CSR_MISA, value);
      expect_eq(value, `MISA_VALUE, "misa");
      finish_test("write masks", start_errors);
   endtask

   task automatic illegal_access();
      int               start_errors;
      logic [`XLEN-1:0] value;
      start_errors = errors;
      csr_access(CSRRW, `CSR_MHARTID, 5'd2, 32'hDEAD_BEEF);
      expect_bit(last_illegal, 1'b1, "write to mhartid flagged");
      read_csr(`CSR_MHARTID, value);
      expect_bit(last_illegal, 1'b0, "read of mhartid flagged");
      expect_eq(value, `MHARTID_VALUE, "mhartid after write attempt");
      csr_access(CSRRW, 12'h7C0, 5'd2, 32'h0BAD_F00D);
      expect_bit(last_illegal, 1'b1, "write to unknown address flagged");
      csr_access(CSRRS, 12'h7C0, 5'd0, '0);
      expect_bit(last_illegal, 1'b1, "read of unknown address flagged");
      read_csr(`CSR_MSCRATCH, value);
      expect_bit(last_illegal, 1'b0, "legal read after illegal one");
      expect_eq(value, 32'h1234_560F, "mscratch after illegal accesses");
      read_csr(`CSR_MSTATUS, value);
      expect_eq(value, `MSTATUS_WMASK, "mstatus after illegal accesses");
      finish_test("illegal accesses", start_errors);
   endtask

   task automatic amo_ops();
      int               start_errors;
      logic [`XLEN-1:0] addr;
      amo_op_t          ops [9];
      logic [`XLEN-1:0] olds [9];
      logic [`XLEN-1:0] rs2s [9];
      logic [`XLEN-1:0] wants [9];
      start_errors = errors;
      ops   = '{AMO_SWAP, AMO_ADD, AMO_AND, AMO_OR, AMO_XOR,
                AMO_MAX, AMO_MIN, AMO_MAXU, AMO_MINU};
      olds  = '{32'h1111_2222, 32'h7FFF_FFFF, 32'hF0F0_F0F0, 32'hF0F0_F0F0, 32'hF0F0_F0F0,
                32'hFFFF_FFF6, 32'hFFFF_FFF6, 32'hFFFF_FFF6, 32'hFFFF_FFF6};
      rs2s  = '{32'hAAAA_5555, 32'h0000_0001, 32'hFF00_FF00, 32'hFF00_FF00, 32'hFF00_FF00,
                32'h0000_0005, 32'h0000_0005, 32'h0000_0005, 32'h0000_0005};
      // -10 against 5, signed and unsigned
      wants = '{32'hAAAA_5555, 32'h8000_0000, 32'hF000_F000, 32'hFFF0_FFF0, 32'h0FF0_0FF0,
                32'h0000_0005, 32'hFFFF_FFF6, 32'hFFFF_FFF6, 32'h0000_0005};
      for (int k = 0; k < 9; k++) begin
         addr = 32'h0000_0080 + 32'(4 * k);
         bus_mem.preload(addr, olds[k]);
         issue_cmd(CMD_AMO, CSRRW, ops[k], 12'h000, 5'd0, addr, rs2s[k], '0);
         expect_eq(last_result, olds[k], $sformatf("%s returns the old word", ops[k].name()));
         expect_eq(bus_mem.peek(addr), wants[k], $sformatf("%s memory word", ops[k].name()));
      end
      finish_test("atomic memory operations", start_errors);
   endtask

   task automatic irq_capture();
      int               start_errors;
      logic [`XLEN-1:0] value;
      start_errors = errors;
      timer_intr    = 1'b1;
      software_intr = 1'b1;
      csr_access(CSRRW, `CSR_MSCRATCH, 5'd6, 32'h5555_AAAA, 32'h0000_2468);
      // cause lands on the edge that ends done
      @(posedge clk);
      #1;
      timer_intr    = 1'b0;
      software_intr = 1'b0;
      read_csr(`CSR_MCAUSE, value);
      expect_eq(value, 32'h8000_0003, "mcause for software over timer");
      read_csr(`CSR_MEPC, value);
      expect_eq(value, 32'h0000_2468, "mepc holds the command pc");
      finish_test("interrupt capture", start_errors);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      clk           = 1'b0;
      rstn          = 1'b1;
      cmd_valid     = 1'b0;
      cmd_kind      = CMD_CSR;
      cmd_csr_op    = CSRRS;
      cmd_amo_op    = AMO_SWAP;
      cmd_csr_addr  = '0;
      cmd_rs1_idx   = '0;
      cmd_rs1       = '0;
      cmd_rs2       = '0;
      cmd_pc        = '0;
      software_intr = 1'b0;
      timer_intr    = 1'b0;
      ext_intr      = 1'b0;
      errors        = 0;
      tests_run     = 0;
      tests_failed  = 0;
      timed_out     = 1'b0;
      last_result   = '0;
      last_illegal  = 1'b0;
      last_cycles   = 0;

      reset_state();
      mscratch_rmw();
      write_masks();
      illegal_access();
      amo_ops();
      irq_capture();

      $display("tests run %0d, tests failed %0d, checks failed %0d",
               tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

/* verilog/amo_alu.sv */
`include "core_consts.svh"

module amo_alu (
   input  amo_pkg::amo_op_t op,
   input  logic [`XLEN-1:0] loaded,
   input  logic [`XLEN-1:0] operand,
   output logic [`XLEN-1:0] value
);
   import amo_pkg::*;

   logic signed_gt;
   logic unsigned_gt;

   assign signed_gt   = $signed(loaded) > $signed(operand);
   assign unsigned_gt = loaded > operand;

   // loaded is the old memory word, operand is rs2
   always_comb begin
      case (op)
         AMO_SWAP: value = operand;
         AMO_ADD:  value = loaded + operand;
         AMO_AND:  value = loaded & operand;
         AMO_OR:   value = loaded | operand;
         AMO_XOR:  value = loaded ^ operand;
         AMO_MAX:  value = signed_gt ? loaded : operand;
         AMO_MIN:  value = signed_gt ? operand : loaded;
         AMO_MAXU: value = unsigned_gt ? loaded : operand;
         AMO_MINU: value = unsigned_gt ? operand : loaded;
         default:  value = loaded;
      endcase
   end

endmodule

/* verilog/csr_amo_core.sv */
`include "core_consts.svh"

module csr_amo_core (
   input  logic               clk,
   input  logic               rstn,
   input  logic               cmd_valid,
   input  amo_pkg::cmd_kind_t cmd_kind,
   input  csr_pkg::csr_op_t   cmd_csr_op,
   input  amo_pkg::amo_op_t   cmd_amo_op,
   input  csr_pkg::csr_addr_t cmd_csr_addr,
   input  logic [4:0]         cmd_rs1_idx,
   input  logic [`XLEN-1:0]   cmd_rs1,
   input  logic [`XLEN-1:0]   cmd_rs2,
   input  logic [`XLEN-1:0]   cmd_pc,
   output logic               busy,
   output logic               done,
   output logic               illegal,
   output logic [`XLEN-1:0]   result,
   // data bus
   output logic               mem_request_enable,
   output logic               mreq_mode,
   output logic [`XLEN-1:0]   mreq_addr,
   output logic [`XLEN-1:0]   mreq_wdata,
   output amo_pkg::mem_strb_t mreq_wstrb,
   input  logic               mem_response_enable,
   input  logic [`XLEN-1:0]   mresp_data,
   // interrupt lines
   input  logic               software_intr,
   input  logic               timer_intr,
   input  logic               ext_intr
);
   import amo_pkg::*;

   csr_if csr_bus ();
   mem_if mem_bus ();

   logic [`XLEN-1:0] amo_loaded;
   logic [`XLEN-1:0] amo_operand;
   logic [`XLEN-1:0] amo_value;
   amo_op_t          amo_op;

   sys_ctrl u_sys_ctrl (
      .clk           (clk),
      .rstn          (rstn),
      .cmd_valid     (cmd_valid),
      .cmd_kind      (cmd_kind),
      .cmd_csr_op    (cmd_csr_op),
      .cmd_amo_op    (cmd_amo_op),
      .cmd_csr_addr  (cmd_csr_addr),
      .cmd_rs1_idx   (cmd_rs1_idx),
      .cmd_rs1       (cmd_rs1),
      .cmd_rs2       (cmd_rs2),
      .cmd_pc        (cmd_pc),
      .software_intr (software_intr),
      .timer_intr    (timer_intr),
      .ext_intr      (ext_intr),
      .amo_value     (amo_value),
      .busy          (busy),
      .done          (done),
      .illegal       (illegal),
      .result        (result),
      .amo_loaded    (amo_loaded),
      .amo_op        (amo_op),
      .amo_operand   (amo_operand),
      .csr_bus       (csr_bus.ctrl),
      .mem_bus       (mem_bus.ctrl)
   );

   csr_file u_csr_file (
      .clk  (clk),
      .rstn (rstn),
      .bus  (csr_bus.csr)
   );

   mem_port u_mem_port (
      .clk                 (clk),
      .rstn                (rstn),
      .req                 (mem_bus.port),
      .mem_request_enable  (mem_request_enable),
      .mreq_mode           (mreq_mode),
      .mreq_addr           (mreq_addr),
      .mreq_wdata          (mreq_wdata),
      .mreq_wstrb          (mreq_wstrb),
      .mem_response_enable (mem_response_enable),
      .mresp_data          (mresp_data)
   );

   amo_alu u_amo_alu (
      .op      (amo_op),
      .loaded  (amo_loaded),
      .operand (amo_operand),
      .value   (amo_value)
   );

endmodule

/* verilog/mem_port.sv */
`include "core_consts.svh"

module mem_port (
   input  logic               clk,
   input  logic               rstn,
   mem_if.port                req,
   output logic               mem_request_enable,
   output logic               mreq_mode,
   output logic [`XLEN-1:0]   mreq_addr,
   output logic [`XLEN-1:0]   mreq_wdata,
   output amo_pkg::mem_strb_t mreq_wstrb,
   input  logic               mem_response_enable,
   input  logic [`XLEN-1:0]   mresp_data
);

   // high from request until response
   logic pending;

   always_ff @(posedge clk) begin
      if (rstn) begin
         mem_request_enable <= 1'b0;
         pending            <= 1'b0;
         req.done           <= 1'b0;
      end else begin
         mem_request_enable <= req.start;
         req.done           <= mem_response_enable && pending;
         if (req.start) begin
            pending <= 1'b1;
         end else if (mem_response_enable) begin
            pending <= 1'b0;
         end
      end
   end

   // request fields stay put until the response
   always_ff @(posedge clk) begin
      if (req.start) begin
         mreq_mode  <= req.write;
         mreq_addr  <= req.addr;
         mreq_wdata <= req.wdata;
         mreq_wstrb <= req.write ? '1 : '0;
      end
      if (mem_response_enable) begin
         req.rdata <= mresp_data;
      end
   end

   a_single_request: assert property (@(posedge clk) disable iff (rstn)
      req.start |-> !pending);

endmodule

/* verilog/sys_ctrl.sv */
`include "core_consts.svh"

module sys_ctrl (
   input  logic                clk,
   input  logic                rstn,
   input  logic                cmd_valid,
   input  amo_pkg::cmd_kind_t  cmd_kind,
   input  csr_pkg::csr_op_t    cmd_csr_op,
   input  amo_pkg::amo_op_t    cmd_amo_op,
   input  csr_pkg::csr_addr_t  cmd_csr_addr,
   input  logic [4:0]          cmd_rs1_idx,
   input  logic [`XLEN-1:0]    cmd_rs1,
   input  logic [`XLEN-1:0]    cmd_rs2,
   input  logic [`XLEN-1:0]    cmd_pc,
   input  logic                software_intr,
   input  logic                timer_intr,
   input  logic                ext_intr,
   input  logic [`XLEN-1:0]    amo_value,
   output logic                busy,
   output logic                done,
   output logic                illegal,
   output logic [`XLEN-1:0]    result,
   output logic [`XLEN-1:0]    amo_loaded,
   output amo_pkg::amo_op_t    amo_op,
   output logic [`XLEN-1:0]    amo_operand,
   csr_if.ctrl                 csr_bus,
   mem_if.ctrl                 mem_bus
);
   import csr_pkg::*;
   import amo_pkg::*;

   typedef enum logic [2:0] {
      IDLE,
      CSR_EXEC,
      CSR_DONE,
      AMO_READ,
      AMO_WRITE,
      FINISH
   } state_t;

   state_t           state;
   csr_op_t          csr_op_q;
   amo_op_t          amo_op_q;
   csr_addr_t        addr_q;
   logic [4:0]       idx_q;
   logic [`XLEN-1:0] rs1_q;
   logic [`XLEN-1:0] rs2_q;
   logic [`XLEN-1:0] pc_q;
   // old csr value or loaded memory word
   logic [`XLEN-1:0] data_q;
   logic             start_q;
   logic             accept;
   logic             any_intr;

   // finish also takes the next command
   assign accept = cmd_valid && !busy;

   ////////////////////////////////////////////////////////////////////////////
   // command and data registers
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (accept) begin
         csr_op_q <= cmd_csr_op;
         amo_op_q <= cmd_amo_op;
         addr_q   <= cmd_csr_addr;
         idx_q    <= cmd_rs1_idx;
         rs1_q    <= cmd_rs1;
         rs2_q    <= cmd_rs2;
         pc_q     <= cmd_pc;
      end
      if (state == CSR_EXEC) begin
         data_q <= csr_bus.rdata;
      end else if ((state == AMO_READ) && mem_bus.done) begin
         data_q <= mem_bus.rdata;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // sequencer
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rstn) begin
         state   <= IDLE;
         busy    <= 1'b0;
         illegal <= 1'b0;
         start_q <= 1'b0;
      end else begin
         start_q <= 1'b0;
         case (state)
            IDLE, FINISH: begin
               state <= IDLE;
               if (accept) begin
                  busy    <= 1'b1;
                  illegal <= 1'b0;
                  if (cmd_kind == CMD_CSR) begin
                     state <= CSR_EXEC;
                  end else begin
                     state   <= AMO_READ;
                     start_q <= 1'b1;
                  end
               end
            end
            // csr write lands on this edge
            CSR_EXEC: begin
               illegal <= !csr_bus.legal;
               state   <= CSR_DONE;
            end
            CSR_DONE: begin
               busy  <= 1'b0;
               state <= FINISH;
            end
            AMO_READ: begin
               if (mem_bus.done) begin
                  start_q <= 1'b1;
                  state   <= AMO_WRITE;
               end
            end
            AMO_WRITE: begin
               if (mem_bus.done) begin
                  busy  <= 1'b0;
                  state <= FINISH;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   assign done        = (state == FINISH);
   assign result      = data_q;
   assign amo_loaded  = data_q;
   assign amo_op      = amo_op_q;
   assign amo_operand = rs2_q;

   // csr side
   assign csr_bus.addr   = addr_q;
   assign csr_bus.op     = csr_op_q;
   assign csr_bus.src    = rs1_q;
   assign csr_bus.zimm   = idx_q;
   assign csr_bus.wr_req = (state == CSR_EXEC);

   // pending interrupts recorded as the command retires
   assign any_intr         = software_intr || timer_intr || ext_intr;
   assign csr_bus.trap_req = done && any_intr;
   assign csr_bus.trap_pc  = pc_q;

   always_comb begin
      if (ext_intr) begin
         csr_bus.trap_cause = IRQ_M_EXT;
      end else if (software_intr) begin
         csr_bus.trap_cause = IRQ_M_SOFT;
      end else begin
         csr_bus.trap_cause = IRQ_M_TIMER;
      end
   end

   // memory side, write data comes from the alu
   assign mem_bus.start = start_q;
   assign mem_bus.write = (state == AMO_WRITE);
   assign mem_bus.addr  = rs1_q;
   assign mem_bus.wdata = amo_value;

   a_cmd_tracked: assert property (@(posedge clk) disable iff (rstn)
      (state != IDLE) |-> (busy || done));

endmodule
